// File: source/clockParams.svh
`ifndef CLOCK_PARAMS_SVH
`define CLOCK_PARAMS_SVH

// ------------------------------------------------------------
// digit limits
// ------------------------------------------------------------
`define TENS_MAX 4'd5 // minutes and seconds tens go 0..5
`define ONES_MAX 4'd9 // ones digits go 0..9

// ------------------------------------------------------------
// key codes, plain ascii
// ------------------------------------------------------------
`define KEY_LOAD_TIME 8'h6C // "l"
`define KEY_LOAD_ALARM 8'h61 // "a"
`define KEY_ARM 8'h40 // "@"
`define KEY_CR 8'h0D // carriage return

// upper nibble shared by "0".."9"
`define DIGIT_PREFIX 4'h3

// ------------------------------------------------------------
// segments
// ------------------------------------------------------------
// gfedcba, active high, so zero is dark
`define SEG_BLANK 7'b0000000

`endif

// File: source/clockTimePkg.sv
package clockTimePkg;

    // one decimal digit in bcd
    typedef logic [3:0] bcdDigit;

    // mm:ss, most significant digit first
    typedef struct packed {
        bcdDigit minTens;
        bcdDigit minOnes;
        bcdDigit secTens;
        bcdDigit secOnes;
    } clockTime;

    // one write strobe per digit position
    typedef struct packed {
        logic minTens;
        logic minOnes;
        logic secTens;
        logic secOnes;
    } digitLoad;

    // segment bits g f e d c b a, active high
    typedef logic [6:0] segPattern;

    // one pattern per digit, laid out like clockTime
    typedef struct packed {
        segPattern minTens;
        segPattern minOnes;
        segPattern secTens;
        segPattern secOnes;
    } segDisplay;

endpackage

// File: source/keyEntryPkg.sv
package keyEntryPkg;

    // digit view of a received byte
    typedef struct packed {
        logic [3:0]           prefix; // 4'h3 for "0".."9"
        clockTimePkg::bcdDigit value; // digit value when prefix matches
    } digitView;

    // same byte, read as a command char or as a digit
    typedef union packed {
        logic [7:0] code;
        digitView   digit;
    } rxByte;

    // decoded key, each flag already qualified by rxValid
    typedef struct packed {
        logic isDigit; // any of 0..9
        logic isTensDigit; // 0..5 only
        logic isLoadTime;
        logic isLoadAlarm;
        logic isArm;
        logic isCr;
    } keyClass;

    // each t*/a* state waits for the named digit
    typedef enum logic [3:0] {
        idle,
        tMinTens,
        tMinOnes,
        tSecTens,
        tSecOnes,
        tEnter, // all time digits in, waiting for cr
        aMinTens,
        aMinOnes,
        aSecTens,
        aSecOnes,
        aEnter // all alarm digits in, waiting for cr
    } entryState;

endpackage

// File: source/keyEntryCtrl.sv
`timescale 1ns/10ps

`include "clockParams.svh"

module keyEntryCtrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rxValid, // one cycle per received byte
    input  keyEntryPkg::rxByte     rxData,
    output clockTimePkg::digitLoad timeLoad,
    output clockTimePkg::digitLoad alarmLoad,
    output clockTimePkg::bcdDigit  loadDigit,
    output logic                   timeRun, // low while time entry is open
    output logic                   entering,
    output logic                   armToggle // pulse on accepted "@"
);
    import keyEntryPkg::*;

    entryState state;
    entryState nextState;
    keyClass   kc;

    // ------------------------------------------------------------
    // key classification, both views of the byte
    // ------------------------------------------------------------
    always_comb
    begin
        kc.isDigit = rxValid && (rxData.digit.prefix == `DIGIT_PREFIX)
                     && (rxData.digit.value <= `ONES_MAX);
        kc.isTensDigit = kc.isDigit && (rxData.digit.value <= `TENS_MAX);
        kc.isLoadTime = rxValid && (rxData.code == `KEY_LOAD_TIME);
        kc.isLoadAlarm = rxValid && (rxData.code == `KEY_LOAD_ALARM);
        kc.isArm = rxValid && (rxData.code == `KEY_ARM);
        kc.isCr = rxValid && (rxData.code == `KEY_CR);
    end

    assign loadDigit = rxData.digit.value; // only sampled under a load strobe

    // ------------------------------------------------------------
    // entry sequence, strobes in the same cycle as the key
    // ------------------------------------------------------------
    always_comb
    begin
        nextState = state; // bad keys leave the state alone
        timeLoad = '0;
        alarmLoad = '0;
        armToggle = 1'b0;
        case (state)
            idle:
            begin
                if (kc.isLoadTime)
                    nextState = tMinTens;
                else if (kc.isLoadAlarm)
                    nextState = aMinTens;
                armToggle = kc.isArm; // "@" counts only here
            end
            tMinTens:
            begin
                timeLoad.minTens = kc.isTensDigit;
                if (kc.isTensDigit)
                    nextState = tMinOnes;
            end
            tMinOnes:
            begin
                timeLoad.minOnes = kc.isDigit;
                if (kc.isDigit)
                    nextState = tSecTens;
            end
            tSecTens:
            begin
                timeLoad.secTens = kc.isTensDigit;
                if (kc.isTensDigit)
                    nextState = tSecOnes;
            end
            tSecOnes:
            begin
                timeLoad.secOnes = kc.isDigit;
                if (kc.isDigit)
                    nextState = tEnter;
            end
            aMinTens:
            begin
                alarmLoad.minTens = kc.isTensDigit;
                if (kc.isTensDigit)
                    nextState = aMinOnes;
            end
            aMinOnes:
            begin
                alarmLoad.minOnes = kc.isDigit;
                if (kc.isDigit)
                    nextState = aSecTens;
            end
            aSecTens:
            begin
                alarmLoad.secTens = kc.isTensDigit;
                if (kc.isTensDigit)
                    nextState = aSecOnes;
            end
            aSecOnes:
            begin
                alarmLoad.secOnes = kc.isDigit;
                if (kc.isDigit)
                    nextState = aEnter;
            end
            tEnter, aEnter:
            begin
                if (kc.isCr)
                    nextState = idle; // entry closes here
            end
            default: nextState = idle; // unused codes recover
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= idle;
        else
            state <= nextState;
    end

    // clock is held from "l" until its cr
    assign timeRun = !(state inside {tMinTens, tMinOnes, tSecTens, tSecOnes, tEnter});
    assign entering = (state != idle);

endmodule

// File: source/timeKeeper.sv
`timescale 1ns/10ps

`include "clockParams.svh"

module timeKeeper (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   secStrobe, // one cycle, once a second
    input  logic                   timeRun,
    input  clockTimePkg::digitLoad timeLoad,
    input  clockTimePkg::bcdDigit  loadDigit,
    output clockTimePkg::clockTime curTime
);
    import clockTimePkg::*;

    logic     tick;
    digitLoad inc; // per-digit count enable

    // next count value, wrapping to 0 past the limit
    function automatic bcdDigit stepDigit(input bcdDigit cur, input bcdDigit limit);
        stepDigit = (cur >= limit) ? 4'd0 : cur + 4'd1;
    endfunction

    // ------------------------------------------------------------
    // carry chain, secOnes up to minTens
    // ------------------------------------------------------------
    assign tick = secStrobe && timeRun;
    assign inc.secOnes = tick;
    assign inc.secTens = inc.secOnes && (curTime.secOnes >= `ONES_MAX);
    assign inc.minOnes = inc.secTens && (curTime.secTens >= `TENS_MAX);
    assign inc.minTens = inc.minOnes && (curTime.minOnes >= `ONES_MAX); // 59:59 -> 00:00

    // loads win over counting
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            curTime <= '0;
        end
        else
        begin
            if (timeLoad.minTens)
                curTime.minTens <= loadDigit;
            else if (inc.minTens)
                curTime.minTens <= stepDigit(curTime.minTens, `TENS_MAX);
            if (timeLoad.minOnes)
                curTime.minOnes <= loadDigit;
            else if (inc.minOnes)
                curTime.minOnes <= stepDigit(curTime.minOnes, `ONES_MAX);
            if (timeLoad.secTens)
                curTime.secTens <= loadDigit;
            else if (inc.secTens)
                curTime.secTens <= stepDigit(curTime.secTens, `TENS_MAX);
            if (timeLoad.secOnes)
                curTime.secOnes <= loadDigit;
            else if (inc.secOnes)
                curTime.secOnes <= stepDigit(curTime.secOnes, `ONES_MAX);
        end
    end

endmodule

// File: source/alarmKeeper.sv
`timescale 1ns/10ps

module alarmKeeper (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   armToggle, // "@" accepted in idle
    input  clockTimePkg::digitLoad alarmLoad,
    input  clockTimePkg::bcdDigit  loadDigit,
    output clockTimePkg::clockTime alarmTime,
    output logic                   armed
);

    // ------------------------------------------------------------
    // alarm digits, one write strobe each
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            alarmTime <= '0; // alarm starts at 00:00
        end
        else
        begin
            if (alarmLoad.minTens)
                alarmTime.minTens <= loadDigit;
            if (alarmLoad.minOnes)
                alarmTime.minOnes <= loadDigit;
            if (alarmLoad.secTens)
                alarmTime.secTens <= loadDigit;
            if (alarmLoad.secOnes)
                alarmTime.secOnes <= loadDigit;
        end
    end

    // armed flag flips on every "@"
    always_ff @(posedge clk)
    begin
        if (rst)
            armed <= 1'b0;
        else if (armToggle)
            armed <= !armed;
    end

endmodule

// File: source/segmentDecoder.sv
`timescale 1ns/10ps

`include "clockParams.svh"

module segmentDecoder (
    input  clockTimePkg::bcdDigit   digit,
    input  logic                    enable, // low forces the digit dark
    output clockTimePkg::segPattern pattern
);

    always_comb
    begin
        if (!enable)
            pattern = `SEG_BLANK;
        else
        begin
            case (digit) // gfedcba
                4'd0: pattern = 7'b0111111;
                4'd1: pattern = 7'b0000110;
                4'd2: pattern = 7'b1011011;
                4'd3: pattern = 7'b1001111;
                4'd4: pattern = 7'b1100110;
                4'd5: pattern = 7'b1101101;
                4'd6: pattern = 7'b1111101;
                4'd7: pattern = 7'b0000111;
                4'd8: pattern = 7'b1111111;
                4'd9: pattern = 7'b1101111;
                default: pattern = `SEG_BLANK; // codes 10..15 stay dark
            endcase
        end
    end

endmodule

// File: source/clockDisplay.sv
`timescale 1ns/10ps

module clockDisplay (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    armed,
    input  logic                    armToggle,
    input  logic                    entering, // blank while keys are being typed
    input  clockTimePkg::clockTime  curTime,
    input  clockTimePkg::clockTime  alarmTime,
    output clockTimePkg::segDisplay segments,
    output logic                    triggered
);
    import clockTimePkg::*;

    logic      match;
    clockTime  shown; // digits picked for the display
    segDisplay segNext;

    // ------------------------------------------------------------
    // alarm match and trigger
    // ------------------------------------------------------------
    assign match = (alarmTime == curTime);

    always_ff @(posedge clk)
    begin
        if (rst)
            triggered <= 1'b0;
        else if (armToggle)
            triggered <= 1'b0; // "@" silences and disarms together
        else if (armed && match)
            triggered <= 1'b1;
    end

    // ------------------------------------------------------------
    // digit select, decode, register
    // ------------------------------------------------------------
    assign shown = triggered ? alarmTime : curTime;

    segmentDecoder decMinTens (.digit(shown.minTens), .enable(!entering),
                               .pattern(segNext.minTens));
    segmentDecoder decMinOnes (.digit(shown.minOnes), .enable(!entering),
                               .pattern(segNext.minOnes));
    segmentDecoder decSecTens (.digit(shown.secTens), .enable(!entering),
                               .pattern(segNext.secTens));
    segmentDecoder decSecOnes (.digit(shown.secOnes), .enable(!entering),
                               .pattern(segNext.secOnes));

    always_ff @(posedge clk)
    begin
        segments <= segNext; // one cycle behind the digits
    end

endmodule

// File: source/alarmClockTop.sv
`timescale 1ns/10ps

module alarmClockTop (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rxValid, // byte strobe from the uart receiver
    input  logic                    secStrobe, // one pulse per second
    input  keyEntryPkg::rxByte      rxData,
    output clockTimePkg::clockTime  curTime,
    output clockTimePkg::clockTime  alarmTime,
    output logic                    armed,
    output logic                    triggered,
    output clockTimePkg::segDisplay segments
);
    import clockTimePkg::*;

    digitLoad timeLoad;
    digitLoad alarmLoad;
    bcdDigit  loadDigit; // shared by both keepers
    logic     timeRun;
    logic     entering;
    logic     armToggle;

    // ------------------------------------------------------------
    // key entry feeds time and alarm side by side
    // ------------------------------------------------------------
    keyEntryCtrl entry (
        .clk(clk), .rst(rst), .rxValid(rxValid), .rxData(rxData),
        .timeLoad(timeLoad), .alarmLoad(alarmLoad), .loadDigit(loadDigit),
        .timeRun(timeRun), .entering(entering), .armToggle(armToggle)
    );

    timeKeeper timeKeep (
        .clk(clk), .rst(rst), .secStrobe(secStrobe), .timeRun(timeRun),
        .timeLoad(timeLoad), .loadDigit(loadDigit), .curTime(curTime)
    );

    alarmKeeper alarmKeep (
        .clk(clk), .rst(rst), .armToggle(armToggle), .alarmLoad(alarmLoad),
        .loadDigit(loadDigit), .alarmTime(alarmTime), .armed(armed)
    );

    // match, trigger and segments
    clockDisplay display (
        .clk(clk), .rst(rst), .armed(armed), .armToggle(armToggle),
        .entering(entering), .curTime(curTime), .alarmTime(alarmTime),
        .segments(segments), .triggered(triggered)
    );

endmodule

// File: sim/clockGen.sv
`timescale 1ns/10ps

module clockGen (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
    end

    always #2 clk = !clk; // 4 ns period

endmodule

// File: sim/alarmClockTb_assert.sv
`timescale 1ns/10ps

`include "clockParams.svh"

module alarmClockTb_assert (
    input logic                   clk,
    input logic                   rst,
    input logic                   armed,
    input logic                   triggered,
    input clockTimePkg::clockTime curTime
);

    int failCount = 0; // assertion failures so far

    // alarm only sounds while armed
    trigNeedsArm: assert property (@(posedge clk) disable iff (rst) triggered |-> armed)
        else
        begin
            $error("triggered is high while the alarm is disarmed");
            failCount++;
        end

    trigRiseArmed: assert property (@(posedge clk) disable iff (rst)
        $rose(triggered) |-> $past(armed)) // rise comes from an armed match
        else
        begin
            $error("triggered rose although armed was low");
            failCount++;
        end

    // ------------------------------------------------------------
    // bcd digits stay inside mm:ss range
    // ------------------------------------------------------------
    digitRange: assert property (@(posedge clk) disable iff (rst)
        (curTime.minTens <= `TENS_MAX) && (curTime.minOnes <= `ONES_MAX)
        && (curTime.secTens <= `TENS_MAX) && (curTime.secOnes <= `ONES_MAX))
        else
        begin
            $error("time digit out of range: %h", curTime);
            failCount++;
        end

endmodule

bind alarmClockTop alarmClockTb_assert timeChecks (.clk(clk), .rst(rst), .armed(armed),
    .triggered(triggered), .curTime(curTime));

// File: sim/alarmClockTb.sv
`timescale 1ns/10ps

`include "clockParams.svh"

module alarmClockTb;
    import clockTimePkg::*;
    import keyEntryPkg::*;

    localparam int ROWS = 13;
    localparam int SETTLE_LIMIT = 40; // cycles per row

    // expected outputs after one table row
    typedef struct packed {
        clockTime curTime;
        clockTime alarmTime;
        logic     armed;
        logic     triggered;
        logic     blank; // entry open, display dark
    } expRow;

    logic      clk;
    logic      rst;
    logic      rxValid;
    logic      secStrobe;
    rxByte     rxData;
    clockTime  curTime;
    clockTime  alarmTime;
    logic      armed;
    logic      triggered;
    segDisplay segments;

    string keyTab[ROWS];
    int    strobeTab[ROWS];
    expRow expTab[ROWS];
    int    rowCount;
    int    errorCount;
    int    checkCount;
    string cr; // one-char string holding carriage return

    clockGen clkGen (.clk(clk));

    alarmClockTop dut (
        .clk(clk), .rst(rst), .rxValid(rxValid), .secStrobe(secStrobe), .rxData(rxData),
        .curTime(curTime), .alarmTime(alarmTime), .armed(armed), .triggered(triggered),
        .segments(segments)
    );

    // reference gfedcba table
    function automatic segPattern digitSegments(input bcdDigit d);
        case (d)
            4'd0: digitSegments = 7'b0111111;
            4'd1: digitSegments = 7'b0000110;
            4'd2: digitSegments = 7'b1011011;
            4'd3: digitSegments = 7'b1001111;
            4'd4: digitSegments = 7'b1100110;
            4'd5: digitSegments = 7'b1101101;
            4'd6: digitSegments = 7'b1111101;
            4'd7: digitSegments = 7'b0000111;
            4'd8: digitSegments = 7'b1111111;
            4'd9: digitSegments = 7'b1101111;
            default: digitSegments = `SEG_BLANK;
        endcase
    endfunction

    function automatic segDisplay expectedSegments(input expRow e);
        clockTime src;
        src = e.triggered ? e.alarmTime : e.curTime; // alarm digits while ringing
        expectedSegments.minTens = e.blank ? `SEG_BLANK : digitSegments(src.minTens);
        expectedSegments.minOnes = e.blank ? `SEG_BLANK : digitSegments(src.minOnes);
        expectedSegments.secTens = e.blank ? `SEG_BLANK : digitSegments(src.secTens);
        expectedSegments.secOnes = e.blank ? `SEG_BLANK : digitSegments(src.secOnes);
    endfunction

    task automatic addRow(input string keys, input int strobes, input clockTime cur,
                          input clockTime alm, input logic arm, input logic trig,
                          input logic blank);
        keyTab[rowCount] = keys;
        strobeTab[rowCount] = strobes;
        expTab[rowCount] = '{cur, alm, arm, trig, blank};
        rowCount++;
    endtask

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    task automatic sendKeys(input string keys);
        int i;
        for (i = 0; i < keys.len(); i++)
        begin
            @(posedge clk);
            rxValid <= 1'b1;
            rxData.code <= keys[i];
            @(posedge clk);
            rxValid <= 1'b0;
            repeat (2) @(posedge clk); // idle gap
        end
    endtask

    task automatic sendStrobes(input int n);
        int i;
        for (i = 0; i < n; i++)
        begin
            @(posedge clk);
            secStrobe <= 1'b1;
            @(posedge clk);
            secStrobe <= 1'b0;
            repeat (2) @(posedge clk);
        end
    endtask

    // wait for the row's state, then compare everything
    task automatic settleAndCheck(input int row, input expRow e);
        int        waited;
        logic      settled;
        segDisplay segExp;
        waited = 0;
        settled = 1'b0;
        segExp = expectedSegments(e);
        while (!settled && waited < SETTLE_LIMIT)
        begin
            @(negedge clk);
            settled = (curTime === e.curTime) && (alarmTime === e.alarmTime)
                      && (armed === e.armed) && (triggered === e.triggered);
            waited++;
        end
        if (!settled)
        begin
            errorCount++;
            $display("row %0d: outputs did not settle within %0d cycles", row, SETTLE_LIMIT);
        end
        repeat (2) @(negedge clk); // segments trail by one register
        checkCount++;
        if (curTime !== e.curTime)
        begin
            errorCount++;
            $display("FAILED at %0t: row %0d curTime %h, expected %h",
                     $time, row, curTime, e.curTime);
        end
        if (alarmTime !== e.alarmTime)
        begin
            errorCount++;
            $display("FAILED at %0t: row %0d alarmTime %h, expected %h",
                     $time, row, alarmTime, e.alarmTime);
        end
        if (armed !== e.armed || triggered !== e.triggered)
        begin
            errorCount++;
            $display("FAILED at %0t: row %0d armed/triggered %b%b, expected %b%b",
                     $time, row, armed, triggered, e.armed, e.triggered);
        end
        if (segments !== segExp)
        begin
            errorCount++;
            $display("FAILED at %0t: row %0d segments %h, expected %h",
                     $time, row, segments, segExp);
        end
    endtask

    initial
    begin
        int r;
        int assertFails;
        rst = 1'b1;
        rxValid = 1'b0;
        secStrobe = 1'b0;
        rxData = '0;
        rowCount = 0;
        errorCount = 0;
        checkCount = 0;
        cr = " ";
        cr[0] = `KEY_CR;

        // keys, strobes, time, alarm, armed, triggered, blank
        addRow("", 0, 16'h0000, 16'h0000, 0, 0, 0); // reset state
        addRow({"l1234", cr}, 0, 16'h1234, 16'h0000, 0, 0, 0);
        addRow("l7x0959", 3, 16'h0959, 16'h0000, 0, 0, 1); // 7 and x dropped, held
        addRow(cr, 0, 16'h0959, 16'h0000, 0, 0, 0);
        addRow("", 1, 16'h1000, 16'h0000, 0, 0, 0);
        addRow({"l5959", cr}, 1, 16'h0000, 16'h0000, 0, 0, 0); // full rollover
        addRow("", 25, 16'h0025, 16'h0000, 0, 0, 0);
        addRow("a00", 2, 16'h0027, 16'h0000, 0, 0, 1); // still counts
        addRow({"30", cr}, 0, 16'h0027, 16'h0030, 0, 0, 0);
        addRow("@", 0, 16'h0027, 16'h0030, 1, 0, 0);
        addRow("", 3, 16'h0030, 16'h0030, 1, 1, 0);
        addRow("", 1, 16'h0031, 16'h0030, 1, 1, 0); // shows alarm digits
        addRow("@", 0, 16'h0031, 16'h0030, 0, 0, 0);

        repeat (16) @(posedge clk);
        rst <= 1'b0;

        for (r = 0; r < rowCount; r++)
        begin
            sendKeys(keyTab[r]);
            sendStrobes(strobeTab[r]);
            settleAndCheck(r, expTab[r]);
        end

        assertFails = dut.timeChecks.failCount; // bound checker on the DUT
        $display("rows checked: %0d, errors: %0d, assertion failures: %0d",
                 checkCount, errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// File: build.f
+incdir+source
source/clockTimePkg.sv
source/keyEntryPkg.sv
source/keyEntryCtrl.sv
source/timeKeeper.sv
source/alarmKeeper.sv
source/segmentDecoder.sv
source/clockDisplay.sv
source/alarmClockTop.sv
sim/clockGen.sv
sim/alarmClockTb_assert.sv
sim/alarmClockTb.sv
